//--- design/soc_bus_pkg.sv
// ------------------------------
// Bus widths and types
// ------------------------------
package soc_bus_pkg;

  // Wishbone classic data path
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned SelWidth  = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [SelWidth-1:0]  sel_t;

  // Slaves behind the fabric
  localparam int unsigned NrSlaves = 3;

  typedef logic [1:0] slave_idx_t;

endpackage

//--- design/soc_map_pkg.sv
// ------------------------------
// Address map and constants
// ------------------------------
package soc_map_pkg;

  // Slave indices on the fabric
  localparam soc_bus_pkg::slave_idx_t RomIdx  = 2'd0;
  localparam soc_bus_pkg::slave_idx_t SramIdx = 2'd1;
  localparam soc_bus_pkg::slave_idx_t CtrlIdx = 2'd2;

  // Address ranges
  localparam soc_bus_pkg::addr_t RomBase    = 32'h0001_0000;
  localparam soc_bus_pkg::addr_t RomLength  = 32'h0000_1000;
  localparam soc_bus_pkg::addr_t SramBase   = 32'h8000_0000;
  localparam soc_bus_pkg::addr_t SramLength = 32'h0000_1000;
  localparam soc_bus_pkg::addr_t CtrlBase   = 32'h0200_0000;
  localparam soc_bus_pkg::addr_t CtrlLength = 32'h0000_1000;

  // Boot image, small spin loop at the reset vector
  localparam int unsigned RomWords = 16;
  localparam soc_bus_pkg::data_t RomContent [RomWords] = '{
    32'h0000_0297, 32'h0202_82b3, 32'h0002_8067, 32'h1050_0073,
    32'hffdf_f06f, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'hdead_beef, 32'hcafe_f00d, 32'h1234_5678, 32'h8765_4321,
    32'h0f0f_0f0f, 32'hf0f0_f0f0, 32'h0000_0001, 32'h8000_0000
  };

  localparam int unsigned SramWords = 1024;

  // Register word offsets in the control block
  localparam int unsigned RegExit    = 0;
  localparam int unsigned RegDbgCtrl = 1;
  localparam int unsigned RegStatus  = 2;

  // Debug request hold-off after reset
  localparam int unsigned DbgHoldCycles = 20;

endpackage

//--- design/addr_decode.sv
// ------------------------------
// Wishbone address decoder
// ------------------------------
module addr_decode (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         wb_cyc_i,
  input  logic                                         wb_stb_i,
  input  soc_bus_pkg::addr_t                           wb_adr_i,
  output soc_bus_pkg::data_t                           wb_dat_o,
  output logic                                         wb_ack_o,
  output logic                                         wb_err_o,
  output logic [soc_bus_pkg::NrSlaves-1:0]             slv_stb_o,
  input  logic [soc_bus_pkg::NrSlaves-1:0]             slv_ack_i,
  input  logic [soc_bus_pkg::NrSlaves-1:0]             slv_err_i,
  input  soc_bus_pkg::data_t [soc_bus_pkg::NrSlaves-1:0] slv_rdata_i
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic                req;
  logic [NrSlaves-1:0] hit;
  logic                any_hit;
  logic                miss;
  logic                err_q;
  slave_idx_t          sel_idx;

  assign req = wb_cyc_i & wb_stb_i;

  // Range compare per slave
  assign hit[RomIdx]  = (wb_adr_i >= RomBase) && (wb_adr_i < RomBase + RomLength);
  assign hit[SramIdx] = (wb_adr_i >= SramBase) && (wb_adr_i < SramBase + SramLength);
  assign hit[CtrlIdx] = (wb_adr_i >= CtrlBase) && (wb_adr_i < CtrlBase + CtrlLength);

  assign any_hit   = |hit;
  assign miss      = req & ~any_hit;
  assign slv_stb_o = hit & {NrSlaves{req}};

  always_comb begin
    sel_idx = RomIdx;
    for (int i = 0; i < NrSlaves; i++) begin
      if (hit[i]) begin
        sel_idx = slave_idx_t'(i);
      end
    end
  end

  // Error for unmapped addresses, one pulse per request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= miss & ~err_q;
    end
  end

  // ------------------------------
  // Response mux
  // ------------------------------
  assign wb_ack_o = any_hit & slv_ack_i[sel_idx];
  assign wb_err_o = err_q | (any_hit & slv_err_i[sel_idx]);
  // Read data only travels with an ack
  assign wb_dat_o = wb_ack_o ? slv_rdata_i[sel_idx] : '0;

  a_stb_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(slv_stb_o))
    else $error("more than one slave strobed");

  a_ack_err_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_ack_o && wb_err_o))
    else $error("ack and err high together");

endmodule

//--- design/boot_rom.sv
// ------------------------------
// Boot ROM slave
// ------------------------------
module boot_rom (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               stb_i,
  input  logic               we_i,
  input  soc_bus_pkg::addr_t adr_i,
  output logic               ack_o,
  output logic               err_o,
  output soc_bus_pkg::data_t rdata_o
);
  import soc_map_pkg::*;

  logic busy;
  logic rd_en;

  // Response already out in this cycle
  assign busy  = ack_o | err_o;
  assign rd_en = stb_i & ~we_i & ~busy;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      ack_o <= rd_en;
      // Writes are refused
      err_o <= stb_i & we_i & ~busy;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_o <= RomContent[adr_i[$clog2(RomWords)+1:2]];
    end
  end

endmodule

//--- design/data_sram.sv
// ------------------------------
// Data SRAM slave
// ------------------------------
module data_sram (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               stb_i,
  input  logic               we_i,
  input  soc_bus_pkg::addr_t adr_i,
  input  soc_bus_pkg::data_t wdata_i,
  input  soc_bus_pkg::sel_t  sel_i,
  output logic               ack_o,
  output soc_bus_pkg::data_t rdata_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  data_t                        mem_q [SramWords];
  logic [$clog2(SramWords)-1:0] word_idx;
  logic                         accept;

  assign word_idx = adr_i[$clog2(SramWords)+1:2];
  assign accept   = stb_i & ~ack_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= accept;
    end
  end

  // ------------------------------
  // Storage with byte lanes
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (we_i) begin
        for (int b = 0; b < SelWidth; b++) begin
          if (sel_i[b]) begin
            mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[word_idx];
      end
    end
  end

  // Strobe stays up from the request through the ack cycle
  a_ack_after_stb : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |-> stb_i && $past(stb_i))
    else $error("ack without a held strobe");

endmodule

//--- design/ctrl_regs.sv
// ------------------------------
// Control register block
// ------------------------------
module ctrl_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               stb_i,
  input  logic               we_i,
  input  soc_bus_pkg::addr_t adr_i,
  input  soc_bus_pkg::data_t wdata_i,
  output logic               ack_o,
  output logic               err_o,
  output soc_bus_pkg::data_t rdata_o,
  input  logic               hold_done_i,
  output soc_bus_pkg::data_t exit_o,
  output logic               dbg_en_o,
  output logic               ndm_req_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic [$clog2(CtrlLength)-3:0] reg_off;
  logic                          accept;
  logic                          wr_ok;
  logic                          wr_bad;
  data_t                         exit_q;

  assign reg_off = adr_i[$clog2(CtrlLength)-1:2];
  assign accept  = stb_i & ~(ack_o | err_o);
  // Writable offsets are EXIT and DBG_CTRL only
  assign wr_ok   = (reg_off == RegExit) || (reg_off == RegDbgCtrl);
  assign wr_bad  = accept & we_i & ~wr_ok;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o     <= 1'b0;
      err_o     <= 1'b0;
      exit_q    <= '0;
      dbg_en_o  <= 1'b1;
      ndm_req_o <= 1'b0;
    end else begin
      ack_o <= accept & ~wr_bad;
      err_o <= wr_bad;
      if (accept && we_i && reg_off == RegExit) begin
        exit_q <= wdata_i;
      end
      if (accept && we_i && reg_off == RegDbgCtrl) begin
        dbg_en_o  <= wdata_i[0];
        ndm_req_o <= wdata_i[1];
      end
    end
  end

  // ------------------------------
  // Read back
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (accept && !we_i) begin
      case (reg_off)
        RegExit:    rdata_o <= exit_q;
        RegDbgCtrl: rdata_o <= {{(DataWidth-2){1'b0}}, ndm_req_o, dbg_en_o};
        RegStatus:  rdata_o <= {{(DataWidth-1){1'b0}}, hold_done_i};
        default:    rdata_o <= '0;
      endcase
    end
  end

  assign exit_o = exit_q;

endmodule

//--- design/dbg_reset_ctrl.sv
// ------------------------------
// Debug gate and core reset
// ------------------------------
module dbg_reset_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic dbg_req_i,
  input  logic dbg_en_i,
  input  logic ndm_req_i,
  output logic hold_done_o,
  output logic dbg_req_o,
  output logic core_rst_no
);
  import soc_map_pkg::*;

  logic [$clog2(DbgHoldCycles+1)-1:0] hold_cnt_q;
  logic [1:0]                         rst_sync_q;

  // Hold-off counter, reloaded on every reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= DbgHoldCycles[$clog2(DbgHoldCycles+1)-1:0];
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign hold_done_o = (hold_cnt_q == '0);
  assign dbg_req_o   = dbg_req_i & dbg_en_i & hold_done_o;

  // ------------------------------
  // Core reset generator
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_sync_q <= 2'b00;
    end else if (ndm_req_i) begin
      // Non-debug-module reset holds the core
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign core_rst_no = rst_sync_q[1];

  a_dbg_holdoff : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(rst_ni) |-> !dbg_req_o [*DbgHoldCycles])
    else $error("debug request passed during hold-off");

endmodule

//--- design/soc_top.sv
// ------------------------------
// SoC bus harness top
// ------------------------------
module soc_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  soc_bus_pkg::addr_t wb_adr_i,
  input  soc_bus_pkg::data_t wb_dat_i,
  input  soc_bus_pkg::sel_t  wb_sel_i,
  output soc_bus_pkg::data_t wb_dat_o,
  output logic               wb_ack_o,
  output logic               wb_err_o,
  input  logic               dbg_req_i,
  output logic               dbg_req_o,
  output logic               core_rst_no,
  output soc_bus_pkg::data_t exit_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic [NrSlaves-1:0]  slv_stb;
  logic [NrSlaves-1:0]  slv_ack;
  logic [NrSlaves-1:0]  slv_err;
  data_t [NrSlaves-1:0] slv_rdata;

  logic dbg_en;
  logic ndm_req;
  logic hold_done;

  // SRAM never refuses an access
  assign slv_err[SramIdx] = 1'b0;

  addr_decode i_addr_decode (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .wb_cyc_i    ( wb_cyc_i  ),
    .wb_stb_i    ( wb_stb_i  ),
    .wb_adr_i    ( wb_adr_i  ),
    .wb_dat_o    ( wb_dat_o  ),
    .wb_ack_o    ( wb_ack_o  ),
    .wb_err_o    ( wb_err_o  ),
    .slv_stb_o   ( slv_stb   ),
    .slv_ack_i   ( slv_ack   ),
    .slv_err_i   ( slv_err   ),
    .slv_rdata_i ( slv_rdata )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i              ),
    .rst_ni  ( rst_ni             ),
    .stb_i   ( slv_stb[RomIdx]    ),
    .we_i    ( wb_we_i            ),
    .adr_i   ( wb_adr_i           ),
    .ack_o   ( slv_ack[RomIdx]    ),
    .err_o   ( slv_err[RomIdx]    ),
    .rdata_o ( slv_rdata[RomIdx]  )
  );

  data_sram i_data_sram (
    .clk_i   ( clk_i              ),
    .rst_ni  ( rst_ni             ),
    .stb_i   ( slv_stb[SramIdx]   ),
    .we_i    ( wb_we_i            ),
    .adr_i   ( wb_adr_i           ),
    .wdata_i ( wb_dat_i           ),
    .sel_i   ( wb_sel_i           ),
    .ack_o   ( slv_ack[SramIdx]   ),
    .rdata_o ( slv_rdata[SramIdx] )
  );

  ctrl_regs i_ctrl_regs (
    .clk_i       ( clk_i              ),
    .rst_ni      ( rst_ni             ),
    .stb_i       ( slv_stb[CtrlIdx]   ),
    .we_i        ( wb_we_i            ),
    .adr_i       ( wb_adr_i           ),
    .wdata_i     ( wb_dat_i           ),
    .ack_o       ( slv_ack[CtrlIdx]   ),
    .err_o       ( slv_err[CtrlIdx]   ),
    .rdata_o     ( slv_rdata[CtrlIdx] ),
    .hold_done_i ( hold_done          ),
    .exit_o      ( exit_o             ),
    .dbg_en_o    ( dbg_en             ),
    .ndm_req_o   ( ndm_req            )
  );

  dbg_reset_ctrl i_dbg_reset_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .dbg_req_i   ( dbg_req_i   ),
    .dbg_en_i    ( dbg_en      ),
    .ndm_req_i   ( ndm_req     ),
    .hold_done_o ( hold_done   ),
    .dbg_req_o   ( dbg_req_o   ),
    .core_rst_no ( core_rst_no )
  );

endmodule

//--- bench/clk_gen.sv
// ------------------------------
// Testbench clock and reset
// ------------------------------
module clk_gen (
  output logic clk_o,
  output logic rst_no
);
  localparam int HalfPeriod  = 4;
  localparam int ResetCycles = 16;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  // Release just after an edge, like any other input
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

//--- bench/tb_soc.sv
// ------------------------------
// SoC bus harness testbench
// ------------------------------
module tb_soc;
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int    DriveDelay = 1;
  localparam int    BusTimeout = 8;
  localparam addr_t ExitAdr    = CtrlBase + addr_t'(4 * RegExit);
  localparam addr_t DbgAdr     = CtrlBase + addr_t'(4 * RegDbgCtrl);
  localparam addr_t StatusAdr  = CtrlBase + addr_t'(4 * RegStatus);

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  addr_t       wb_adr;
  data_t       wb_wdat;
  sel_t        wb_sel;
  data_t       wb_rdat;
  logic        wb_ack;
  logic        wb_err;
  logic        dbg_req_in;
  logic        dbg_req_out;
  logic        core_rst_n;
  data_t       exit_code;
  int unsigned mismatch_cnt;
  int unsigned other_cnt;
  int unsigned since_rst;
  integer      seed;

  clk_gen i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  soc_top dut_i (
    .clk_i       ( clk         ),
    .rst_ni      ( rst_n       ),
    .wb_cyc_i    ( wb_cyc      ),
    .wb_stb_i    ( wb_stb      ),
    .wb_we_i     ( wb_we       ),
    .wb_adr_i    ( wb_adr      ),
    .wb_dat_i    ( wb_wdat     ),
    .wb_sel_i    ( wb_sel      ),
    .wb_dat_o    ( wb_rdat     ),
    .wb_ack_o    ( wb_ack      ),
    .wb_err_o    ( wb_err      ),
    .dbg_req_i   ( dbg_req_in  ),
    .dbg_req_o   ( dbg_req_out ),
    .core_rst_no ( core_rst_n  ),
    .exit_o      ( exit_code   )
  );

  // Cycles since reset release
  always @(posedge clk) begin
    if (!rst_n) begin
      since_rst <= 0;
    end else begin
      since_rst <= since_rst + 1;
    end
  end

  task automatic compare_value(input string name, input data_t exp_v, input data_t act_v);
    if (act_v !== exp_v) begin
      mismatch_cnt++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  function automatic data_t merge_bytes(data_t old_w, data_t new_w, sel_t sel);
    data_t res;
    res = old_w;
    for (int b = 0; b < SelWidth; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // ------------------------------
  // One Wishbone classic cycle
  // ------------------------------
  task automatic bus_xfer(input logic we, input addr_t adr, input data_t wdat, input sel_t sel,
                          output data_t rdata, output logic ack, output logic err);
    int waited;
    @(posedge clk);
    #DriveDelay;
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = wdat;
    wb_sel  = sel;
    waited  = 0;
    ack     = 1'b0;
    err     = 1'b0;
    rdata   = '0;
    // Sample on the falling edge, away from register updates
    while (!ack && !err && waited < BusTimeout) begin
      @(negedge clk);
      ack   = wb_ack;
      err   = wb_err;
      rdata = wb_rdat;
      waited++;
    end
    if (!ack && !err) begin
      other_cnt++;
      $display("Timeout: no ack or err for the access to address %h", adr);
    end
    @(posedge clk);
    #DriveDelay;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wait_core_rst(input logic level, input int max_cycles, input string what);
    int n;
    n = 0;
    while (core_rst_n !== level && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (core_rst_n !== level) begin
      other_cnt++;
      $display("Timeout: core_rst_no did not reach %b %s", level, what);
    end
  endtask

  task automatic probe_debug_gate();
    data_t rdata;
    logic  ack;
    logic  err;
    logic  dbg_seen;
    int    polls;
    rdata = '0;
    polls = 0;
    // Hold-off is monotonic, so an earlier sample can only be lower
    while (rdata[0] !== 1'b1 && polls < 40) begin
      dbg_seen = dbg_req_out;
      bus_xfer(1'b0, StatusAdr, '0, 4'hf, rdata, ack, err);
      if (rdata[0] !== 1'b1) begin
        compare_value("dbg_req_o during hold-off", 0, dbg_seen);
      end
      polls++;
    end
    if (rdata[0] !== 1'b1) begin
      other_cnt++;
      $display("Timeout: STATUS never reported the end of the hold-off");
    end else begin
      compare_value("hold-off length", 1, since_rst >= DbgHoldCycles);
    end
    dbg_req_in = 1'b0;
    #1 compare_value("dbg_req_o follows low", 0, dbg_req_out);
    dbg_req_in = 1'b1;
    #1 compare_value("dbg_req_o follows high", 1, dbg_req_out);
    bus_xfer(1'b1, DbgAdr, 32'h0, 4'hf, rdata, ack, err);
    compare_value("dbg_req_o with debug disabled", 0, dbg_req_out);
    bus_xfer(1'b1, DbgAdr, 32'h1, 4'hf, rdata, ack, err);
  endtask

  task automatic toggle_ndm_reset();
    data_t rdata;
    logic  ack;
    logic  err;
    bus_xfer(1'b1, DbgAdr, 32'h3, 4'hf, rdata, ack, err);
    wait_core_rst(1'b0, 2, "after the ndm reset request");
    bus_xfer(1'b1, DbgAdr, 32'h1, 4'hf, rdata, ack, err);
    compare_value("core_rst_no one cycle after ndm clear", 0, core_rst_n);
    wait_core_rst(1'b1, 2, "after the ndm reset request was cleared");
  endtask

  // ------------------------------
  // Transactions from the data file
  // ------------------------------
  task automatic run_stim_file();
    int                 fd;
    int                 code;
    int                 entry;
    logic [7:0]         op_s;
    logic [23:0]        resp_s;
    logic [8*128-1:0]   rest;
    addr_t              adr;
    data_t              wdat;
    sel_t               sel;
    data_t              exp_rd;
    data_t              rdata;
    logic               ack;
    logic               err;
    logic [1:0]         exp_rsp;
    string              name;
    fd = $fopen("bench/stim_input.txt", "r");
    if (fd == 0) begin
      other_cnt++;
      $display("Could not open bench/stim_input.txt");
      return;
    end
    entry = 0;
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", op_s);
      if (code != 1) begin
        break;
      end
      if (op_s == "#") begin
        code = $fgets(rest, fd);
        continue;
      end
      code = $fscanf(fd, "%h %h %h %h %s", adr, wdat, sel, exp_rd, resp_s);
      if (code != 5) begin
        other_cnt++;
        $display("Malformed entry after entry %0d in the stimulus file", entry);
        break;
      end
      entry++;
      name = $sformatf("stim entry %0d", entry);
      bus_xfer(op_s == "W", adr, wdat, sel, rdata, ack, err);
      // Response as {err, ack}
      exp_rsp = (resp_s == "ERR") ? 2'b10 : 2'b01;
      compare_value({name, " response"}, {30'b0, exp_rsp}, {30'b0, err, ack});
      // Errors carry zero read data on reads and writes alike
      if (op_s == "R" || exp_rsp == 2'b10) begin
        compare_value({name, " read data"}, exp_rd, rdata);
      end
    end
    $fclose(fd);
  endtask

  task automatic sram_random_rw();
    integer rnd;
    addr_t  adr;
    data_t  base;
    data_t  wdat;
    sel_t   sel;
    data_t  rdata;
    logic   ack;
    logic   err;
    for (int i = 0; i < 32; i++) begin
      rnd  = $random(seed);
      adr  = SramBase | {20'b0, rnd[9:0], 2'b00};
      base = $random(seed);
      wdat = $random(seed);
      rnd  = $random(seed);
      sel  = rnd[3:0];
      // Full word first so that every byte is known
      bus_xfer(1'b1, adr, base, 4'hf, rdata, ack, err);
      bus_xfer(1'b1, adr, wdat, sel, rdata, ack, err);
      bus_xfer(1'b0, adr, '0, 4'hf, rdata, ack, err);
      compare_value($sformatf("sram random %0d", i), merge_bytes(base, wdat, sel), rdata);
    end
  endtask

  task automatic exit_code_roundtrip();
    data_t rdata;
    logic  ack;
    logic  err;
    bus_xfer(1'b1, ExitAdr, 32'h00c0_ffee, 4'hf, rdata, ack, err);
    compare_value("exit_o after write", 32'h00c0_ffee, exit_code);
    bus_xfer(1'b0, ExitAdr, '0, 4'hf, rdata, ack, err);
    compare_value("EXIT read back", 32'h00c0_ffee, rdata);
  endtask

  initial begin : main_seq
    int n;
    mismatch_cnt = 0;
    other_cnt    = 0;
    seed         = 79;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_wdat      = '0;
    wb_sel       = '0;
    dbg_req_in   = 1'b1;

    // Outputs while reset is held
    @(negedge clk);
    compare_value("core_rst_no in reset", 0, core_rst_n);
    compare_value("dbg_req_o in reset", 0, dbg_req_out);
    compare_value("ack and err in reset", 0, {wb_err, wb_ack});
    compare_value("exit_o in reset", 0, exit_code);
    n = 0;
    while (!rst_n && n < 40) begin
      @(negedge clk);
      n++;
    end
    if (!rst_n) begin
      other_cnt++;
      $display("Timeout: reset was never released");
    end
    wait_core_rst(1'b1, 4, "after reset release");

    probe_debug_gate();
    toggle_ndm_reset();
    run_stim_file();
    sram_random_rw();
    exit_code_roundtrip();

    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- bench/stim_input.txt
# op addr wdata sel exp_rdata resp
# op is R or W, resp is ACK or ERR, numbers in hex
R 00010000 00000000 f 00000297 ACK
R 00010004 00000000 f 020282b3 ACK
R 00010020 00000000 f deadbeef ACK
R 0001003c 00000000 f 80000000 ACK
R 00010040 00000000 f 00000297 ACK
W 00010008 12345678 f 00000000 ERR
R 0001000c 00000000 f 10500073 ACK
W 80000000 11223344 f 00000000 ACK
W 80000000 aabbccdd 5 00000000 ACK
R 80000000 00000000 f 11bb33dd ACK
W 80000ffc 00000000 f 00000000 ACK
W 80000ffc cafebabe a 00000000 ACK
R 80000ffc 00000000 f ca00ba00 ACK
R 40000000 00000000 f 00000000 ERR
W 00000000 55aa55aa f 00000000 ERR
R 00011000 00000000 f 00000000 ERR
R 02001000 00000000 f 00000000 ERR
W 02000008 00000001 f 00000000 ERR
R 80000000 00000000 f 11bb33dd ACK

//--- all.f
design/soc_bus_pkg.sv
design/soc_map_pkg.sv
design/addr_decode.sv
design/boot_rom.sv
design/data_sram.sv
design/ctrl_regs.sv
design/dbg_reset_ctrl.sv
design/soc_top.sv
bench/clk_gen.sv
bench/tb_soc.sv

//--- Bender.yml
package:
  name: soc_bus_harness

sources:
  # Packages first, then the slaves, then the top level
  - files:
      - design/soc_bus_pkg.sv
      - design/soc_map_pkg.sv
      - design/addr_decode.sv
      - design/boot_rom.sv
      - design/data_sram.sv
      - design/ctrl_regs.sv
      - design/dbg_reset_ctrl.sv
      - design/soc_top.sv

  # Testbench sources
  - target: test
    files:
      - bench/clk_gen.sv
      - bench/tb_soc.sv
